/* Bender.yml */
package:
  name: glay_memory_fabric

sources:
  - files:
      - verilog/glay_mem_pkg.sv
      - verilog/sync_fifo.sv
      - verilog/request_arbiter_n_to_1.sv
      - verilog/scratchpad_memory.sv
      - verilog/response_demux_1_to_n.sv
      - verilog/memory_fabric_top.sv
  - target: test
    files:
      - tb/memory_fabric_asserts.sv
      - tb/memory_fabric_tb.sv

/* glay_memory_fabric.f */
verilog/glay_mem_pkg.sv
verilog/sync_fifo.sv
verilog/request_arbiter_n_to_1.sv
verilog/scratchpad_memory.sv
verilog/response_demux_1_to_n.sv
verilog/memory_fabric_top.sv
tb/memory_fabric_asserts.sv
tb/memory_fabric_tb.sv

/* tb/memory_fabric_asserts.sv */
// Port-level properties of the fabric. Fairness counts only accepted requests of
// other ports, so cycles with a full request queue do not count as waiting
`timescale 1ns/10ps

module memory_fabric_asserts (
  input logic                                    ap_clk,
  input logic                                    areset_control,
  input logic [glay_mem_pkg::num_requestors-1:0] req_valid,
  input logic [glay_mem_pkg::num_requestors-1:0] req_ready,
  input logic [glay_mem_pkg::num_requestors-1:0] resp_valid,
  input logic [glay_mem_pkg::num_requestors-1:0] resp_ready,
  input glay_mem_pkg::mem_response_t             resp [glay_mem_pkg::num_requestors]
);

  // Number of failed properties so far
  int unsigned failures = 0;

  reset_clears_ports: assert property (@(posedge ap_clk)
    areset_control |=> (req_ready == '0) && (resp_valid == '0))
    else begin
      failures++;
      $error("req_ready or resp_valid high right after reset");
    end

  // ----------------------------------------------------------------------
  // Per-port checks
  // ----------------------------------------------------------------------

  for (genvar i = 0; i < glay_mem_pkg::num_requestors; i++) begin : g_port
    logic [7:0] wait_count;
    logic       accepted_self;
    logic       accepted_other;

    assign accepted_self  = req_valid[i] & req_ready[i];
    assign accepted_other = |(req_valid & req_ready & ~(glay_mem_pkg::route_t'(1) << i));

    // Requests of other ports served while this one waits
    always_ff @(posedge ap_clk) begin
      if (areset_control) begin
        wait_count <= '0;
      end else if (!req_valid[i] || accepted_self) begin
        wait_count <= '0;
      end else if (accepted_other) begin
        wait_count <= wait_count + 1'b1;
      end
    end

    route_matches_port: assert property (@(posedge ap_clk) disable iff (areset_control)
      resp_valid[i] |-> resp[i].route == (glay_mem_pkg::route_t'(1) << i))
      else begin
        failures++;
        $error("Port %0d carries a response routed elsewhere", i);
      end

    stall_holds_resp: assert property (@(posedge ap_clk) disable iff (areset_control)
      resp_valid[i] && !resp_ready[i] |=> resp_valid[i] && $stable(resp[i]))
      else begin
        failures++;
        $error("Port %0d response changed or vanished during a stall", i);
      end

    round_robin_bound: assert property (@(posedge ap_clk) disable iff (areset_control)
      wait_count <= glay_mem_pkg::num_requestors - 1)
      else begin
        failures++;
        $error("Port %0d waited past a full round of other grants", i);
      end
  end

endmodule

/* tb/memory_fabric_tb.sv */
// Random traffic on every port with each port in its own address slice. Reads only hit
// words that the port wrote first, so no unwritten scratchpad word is ever returned
`timescale 1ns/10ps

module memory_fabric_tb;

  localparam int n_ports         = glay_mem_pkg::num_requestors;
  localparam int reqs_per_port   = 60;
  localparam int slice_words     = (2 ** glay_mem_pkg::addr_width) / n_ports;
  localparam int watchdog_cycles = n_ports * reqs_per_port * 200 + 1000;

  typedef logic [glay_mem_pkg::addr_width-1:0] addr_t;

  logic                           ap_clk;
  logic                           areset_control;
  logic [n_ports-1:0]             req_valid;
  logic [n_ports-1:0]             req_ready;
  glay_mem_pkg::requestor_req_t   req [n_ports];
  logic [n_ports-1:0]             resp_valid;
  logic [n_ports-1:0]             resp_ready;
  glay_mem_pkg::mem_response_t    resp [n_ports];

  // Scoreboard with expected responses per port in acceptance order
  glay_mem_pkg::mem_response_t          expected [n_ports][reqs_per_port];
  logic [glay_mem_pkg::data_width-1:0]  shadow [2 ** glay_mem_pkg::addr_width];
  int                                   issued [n_ports];
  int                                   received [n_ports];
  int                                   stall_left [n_ports];
  integer                               seed = 32'h60645d62;

  memory_fabric_top dut_i (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .req_valid     (req_valid),
    .req_ready     (req_ready),
    .req           (req),
    .resp_valid    (resp_valid),
    .resp_ready    (resp_ready),
    .resp          (resp)
  );

  bind memory_fabric_top memory_fabric_asserts asserts_i (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .req_valid     (req_valid),
    .req_ready     (req_ready),
    .resp_valid    (resp_valid),
    .resp_ready    (resp_ready),
    .resp          (resp)
  );

  always #4 ap_clk = ~ap_clk;

  task automatic stop_with_failure();
    $display("Simulation FAILED");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic flag_mismatch(input int port, input string what);
    $display("[ERROR] %0t: port %0d %s", $time, port, what);
    stop_with_failure();
  endtask

  function automatic bit all_received();
    for (int p = 0; p < n_ports; p++) begin
      if (received[p] != reqs_per_port) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  // The first slice_words requests of a port write each word of its slice once
  task automatic make_request(input int port, output glay_mem_pkg::requestor_req_t r);
    int slot;
    if (issued[port] < slice_words) begin
      slot  = issued[port];
      r.cmd = glay_mem_pkg::cmd_write;
    end else begin
      slot  = $random(seed) & (slice_words - 1);
      r.cmd = ($random(seed) & 1) ? glay_mem_pkg::cmd_write : glay_mem_pkg::cmd_read;
    end
    r.address = addr_t'(port * slice_words + slot);
    r.data    = $random(seed);
  endtask

  // Reads see the last write and writes echo their own data
  task automatic record_accept(input int port);
    glay_mem_pkg::mem_response_t exp_resp;
    exp_resp.route   = glay_mem_pkg::route_t'(1) << port;
    exp_resp.cmd     = req[port].cmd;
    exp_resp.address = req[port].address;
    if (req[port].cmd == glay_mem_pkg::cmd_write) begin
      shadow[req[port].address] = req[port].data;
    end
    exp_resp.data = shadow[req[port].address];
    expected[port][issued[port]] = exp_resp;
    issued[port]++;
  endtask

  task automatic check_response(input int port);
    if (resp_valid[port] && resp_ready[port]) begin
      assert (received[port] < issued[port])
        else flag_mismatch(port, "received a response with none outstanding");
      assert (resp[port] === expected[port][received[port]])
        else flag_mismatch(port, $sformatf("got response %h, expected %h",
                                           resp[port], expected[port][received[port]]));
      received[port]++;
    end
  endtask

  // Payload is held until the transfer and the next request may follow at once
  task automatic drive_request(input int port);
    glay_mem_pkg::requestor_req_t next_req;
    logic busy;
    busy = req_valid[port];
    if (req_valid[port] && req_ready[port]) begin
      record_accept(port);
      busy = 1'b0;
    end
    if (!busy) begin
      if (issued[port] < reqs_per_port && ($random(seed) & 7) != 0) begin
        make_request(port, next_req);
        req[port]       <= next_req;
        req_valid[port] <= 1'b1;
      end else begin
        req_valid[port] <= 1'b0;
      end
    end
  endtask

  task automatic drive_ready(input int port);
    if (stall_left[port] > 0) begin
      stall_left[port]--;
      resp_ready[port] <= 1'b0;
    end else if (issued[port] < reqs_per_port && ($random(seed) & 63) == 0) begin
      // Long stall that can fill the shared response queue
      stall_left[port] = 40 + ($random(seed) & 63);
      resp_ready[port] <= 1'b0;
    end else begin
      resp_ready[port] <= (($random(seed) & 3) != 0);
    end
  endtask

  always @(posedge ap_clk) begin
    if (!areset_control) begin
      for (int p = 0; p < n_ports; p++) begin
        check_response(p);
        drive_request(p);
        drive_ready(p);
      end
    end
  end

  always @(negedge ap_clk) begin
    if (dut_i.asserts_i.failures != 0) begin
      $display("A bound protocol assertion failed, see the assertion error above");
      stop_with_failure();
    end
  end

  initial begin
    repeat (watchdog_cycles) @(posedge ap_clk);
    $display("Watchdog expired after %0d cycles: the run hung before all responses arrived",
             watchdog_cycles);
    stop_with_failure();
  end

  initial begin
    ap_clk         = 1'b0;
    areset_control = 1'b1;
    req_valid      = '0;
    resp_ready     = '0;
    for (int p = 0; p < n_ports; p++) begin
      req[p]        = '0;
      issued[p]     = 0;
      received[p]   = 0;
      stall_left[p] = 0;
    end
    repeat (10) @(posedge ap_clk);
    areset_control <= 1'b0;
    while (!all_received()) begin
      @(negedge ap_clk);
    end
    // Idle tail so a stray response would still show up
    repeat (20) @(negedge ap_clk);
    if (dut_i.asserts_i.failures == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      stop_with_failure();
    end
  end

endmodule

/* verilog/glay_mem_pkg.sv */
// Shared types for the scratchpad response path. num_requestors must be a power of two
// because the arbiter pointer wraps by overflow
package glay_mem_pkg;

  // ----------------------------------------------------------------------
  // Sizing
  // ----------------------------------------------------------------------

  // Requestor ports on the fabric
  localparam int num_requestors = 4;

  // Width of a requestor index, used by the round-robin pointer
  localparam int requestor_id_width = $clog2(num_requestors);

  // 64-word scratchpad
  localparam int addr_width = 6;
  localparam int data_width = 32;

  // Queue depths
  localparam int req_fifo_depth  = 4;
  localparam int resp_fifo_depth = 16;

  // ----------------------------------------------------------------------
  // Types
  // ----------------------------------------------------------------------

  typedef logic [requestor_id_width-1:0] requestor_id_t;

  // One-hot requestor mask, one bit per port
  typedef logic [num_requestors-1:0] route_t;

  typedef enum logic {
    cmd_read  = 1'b0,
    cmd_write = 1'b1
  } mem_cmd_t;

  // What a requestor sends
  typedef struct packed {
    mem_cmd_t                cmd;
    logic [addr_width-1:0]   address;
    logic [data_width-1:0]   data;
  } requestor_req_t;

  // Request after arbitration, stamped with its source mask
  typedef struct packed {
    route_t                  route;
    mem_cmd_t                cmd;
    logic [addr_width-1:0]   address;
    logic [data_width-1:0]   data;
  } mem_request_t;

  // Read data, or the written word as a write acknowledgement
  typedef struct packed {
    route_t                  route;
    mem_cmd_t                cmd;
    logic [addr_width-1:0]   address;
    logic [data_width-1:0]   data;
  } mem_response_t;

endpackage

/* verilog/memory_fabric_top.sv */
// Shared scratchpad behind a round-robin arbiter and a response demux.
// Response latency depends on contention and on per-port back-pressure
`timescale 1ns/10ps

module memory_fabric_top (
  input  logic                                ap_clk,
  input  logic                                areset_control,
  input  logic [glay_mem_pkg::num_requestors-1:0] req_valid,
  output logic [glay_mem_pkg::num_requestors-1:0] req_ready,
  input  glay_mem_pkg::requestor_req_t        req [glay_mem_pkg::num_requestors],
  output logic [glay_mem_pkg::num_requestors-1:0] resp_valid,
  input  logic [glay_mem_pkg::num_requestors-1:0] resp_ready,
  output glay_mem_pkg::mem_response_t         resp [glay_mem_pkg::num_requestors]
);

  // Arbiter to scratchpad
  logic                        mem_req_valid;
  logic                        mem_req_ready;
  glay_mem_pkg::mem_request_t  mem_req;

  // Scratchpad to demux
  logic                        mem_resp_valid;
  logic                        mem_resp_ready;
  glay_mem_pkg::mem_response_t mem_resp;

  request_arbiter_n_to_1 arbiter_i (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .req_valid     (req_valid),
    .req_ready     (req_ready),
    .req           (req),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .mem_req_ready (mem_req_ready)
  );

  scratchpad_memory scratchpad_i (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .mem_req       (mem_req),
    .mem_resp_valid(mem_resp_valid),
    .mem_resp      (mem_resp),
    .mem_resp_ready(mem_resp_ready)
  );

  response_demux_1_to_n demux_i (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .mem_resp_valid(mem_resp_valid),
    .mem_resp_ready(mem_resp_ready),
    .mem_resp      (mem_resp),
    .resp_valid    (resp_valid),
    .resp_ready    (resp_ready),
    .resp          (resp)
  );

endmodule

/* verilog/request_arbiter_n_to_1.sv */
// Round-robin merge of the requestor streams. The grant is registered, so a new request
// waits at least one cycle for its grant before it can transfer
`timescale 1ns/10ps

module request_arbiter_n_to_1 (
  input  logic                                ap_clk,
  input  logic                                areset_control,
  input  logic [glay_mem_pkg::num_requestors-1:0] req_valid,
  output logic [glay_mem_pkg::num_requestors-1:0] req_ready,
  input  glay_mem_pkg::requestor_req_t        req [glay_mem_pkg::num_requestors],
  output logic                                mem_req_valid,
  output glay_mem_pkg::mem_request_t          mem_req,
  input  logic                                mem_req_ready
);

  glay_mem_pkg::route_t        grant_q;
  glay_mem_pkg::route_t        next_grant;
  glay_mem_pkg::requestor_id_t grant_idx;
  glay_mem_pkg::requestor_id_t rr_ptr;
  glay_mem_pkg::requestor_id_t search_base;
  glay_mem_pkg::mem_request_t  push_data;

  logic fifo_push_ready;
  logic accept;
  logic regrant;

  // ----------------------------------------------------------------------
  // Grant selection
  // ----------------------------------------------------------------------

  // Ready comes from registered grant and queue state only
  assign req_ready = grant_q & {glay_mem_pkg::num_requestors{fifo_push_ready}};
  assign accept    = |(req_valid & req_ready);

  // Re-arbitrate after a transfer or when the granted port went idle
  assign regrant   = accept | ~(|(grant_q & req_valid));

  // Start the search just past the port that was served
  assign search_base = accept ? grant_idx + 1'b1 : rr_ptr;

  always_comb begin
    grant_idx = '0;
    for (int k = 0; k < glay_mem_pkg::num_requestors; k++) begin
      if (grant_q[k]) begin
        grant_idx = glay_mem_pkg::requestor_id_t'(k);
      end
    end
  end

  // Walk backwards so the closest valid port to the base wins
  always_comb begin : next_grant_search
    glay_mem_pkg::requestor_id_t idx;
    next_grant = '0;
    for (int k = glay_mem_pkg::num_requestors - 1; k >= 0; k--) begin
      idx = search_base + glay_mem_pkg::requestor_id_t'(k);
      if (req_valid[idx]) begin
        next_grant = glay_mem_pkg::route_t'(1) << idx;
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      grant_q <= '0;
      rr_ptr  <= '0;
    end else begin
      if (regrant) begin
        grant_q <= next_grant;
      end
      if (accept) begin
        rr_ptr <= grant_idx + 1'b1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Route stamping and request queue
  // ----------------------------------------------------------------------

  assign push_data.route   = grant_q;
  assign push_data.cmd     = req[grant_idx].cmd;
  assign push_data.address = req[grant_idx].address;
  assign push_data.data    = req[grant_idx].data;

  sync_fifo #(
    .payload_t(glay_mem_pkg::mem_request_t),
    .depth    (glay_mem_pkg::req_fifo_depth)
  ) req_fifo_i (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .push_valid    (accept),
    .push_data     (push_data),
    .push_ready    (fifo_push_ready),
    .pop_valid     (mem_req_valid),
    .pop_data      (mem_req),
    .pop_ready     (mem_req_ready),
    .free_count    ()
  );

endmodule

/* verilog/response_demux_1_to_n.sv */
// Queues memory responses and steers each to the port in its route mask.
// One stalled port holds the head and so blocks every other port
`timescale 1ns/10ps

module response_demux_1_to_n (
  input  logic                                ap_clk,
  input  logic                                areset_control,
  input  logic                                mem_resp_valid,
  output logic                                mem_resp_ready,
  input  glay_mem_pkg::mem_response_t         mem_resp,
  output logic [glay_mem_pkg::num_requestors-1:0] resp_valid,
  input  logic [glay_mem_pkg::num_requestors-1:0] resp_ready,
  output glay_mem_pkg::mem_response_t         resp [glay_mem_pkg::num_requestors]
);

  glay_mem_pkg::mem_response_t in_data_q;
  glay_mem_pkg::mem_response_t head;
  glay_mem_pkg::route_t        can_load;

  logic                                       in_valid_q;
  logic                                       head_valid;
  logic                                       pop_ready;
  logic                                       pop;
  logic [$clog2(glay_mem_pkg::resp_fifo_depth+1)-1:0] free_count;

  // ----------------------------------------------------------------------
  // Input register
  // ----------------------------------------------------------------------

  // Keep room for the entry sitting in the input register
  assign mem_resp_ready = (free_count > 2);

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      in_valid_q <= 1'b0;
    end else begin
      in_valid_q <= mem_resp_valid & mem_resp_ready;
    end
  end

  always_ff @(posedge ap_clk) begin
    in_data_q <= mem_resp;
  end

  sync_fifo #(
    .payload_t(glay_mem_pkg::mem_response_t),
    .depth    (glay_mem_pkg::resp_fifo_depth)
  ) resp_fifo_i (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .push_valid    (in_valid_q),
    .push_data     (in_data_q),
    .push_ready    (),
    .pop_valid     (head_valid),
    .pop_data      (head),
    .pop_ready     (pop_ready),
    .free_count    (free_count)
  );

  // ----------------------------------------------------------------------
  // Steering
  // ----------------------------------------------------------------------

  // Slot can take a word when empty or handing its word over
  assign can_load  = ~resp_valid | resp_ready;

  // All routed slots must be able to load
  assign pop_ready = ((head.route & can_load) == head.route);
  assign pop       = head_valid & pop_ready;

  for (genvar i = 0; i < glay_mem_pkg::num_requestors; i++) begin : g_out_stage
    always_ff @(posedge ap_clk) begin
      if (areset_control) begin
        resp_valid[i] <= 1'b0;
      end else if (can_load[i]) begin
        resp_valid[i] <= pop & head.route[i];
      end
    end

    always_ff @(posedge ap_clk) begin
      if (pop && head.route[i]) begin
        resp[i] <= head;
      end
    end
  end

endmodule

/* verilog/scratchpad_memory.sv */
// Single-port scratchpad with one output register. Memory contents are undefined
// until written; reads of unwritten words return X in simulation
`timescale 1ns/10ps

module scratchpad_memory (
  input  logic                        ap_clk,
  input  logic                        areset_control,
  input  logic                        mem_req_valid,
  output logic                        mem_req_ready,
  input  glay_mem_pkg::mem_request_t  mem_req,
  output logic                        mem_resp_valid,
  output glay_mem_pkg::mem_response_t mem_resp,
  input  logic                        mem_resp_ready
);

  logic [glay_mem_pkg::data_width-1:0] words [2**glay_mem_pkg::addr_width];

  logic accept;
  logic is_write;

  // Take a new request when the output slot is free or draining
  assign mem_req_ready = ~mem_resp_valid | mem_resp_ready;
  assign accept        = mem_req_valid & mem_req_ready;
  assign is_write      = (mem_req.cmd == glay_mem_pkg::cmd_write);

  // ----------------------------------------------------------------------
  // Word array
  // ----------------------------------------------------------------------

  always_ff @(posedge ap_clk) begin
    if (accept && is_write) begin
      words[mem_req.address] <= mem_req.data;
    end
  end

  // ----------------------------------------------------------------------
  // Response register
  // ----------------------------------------------------------------------

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      mem_resp_valid <= 1'b0;
    end else if (accept) begin
      mem_resp_valid <= 1'b1;
    end else if (mem_resp_ready) begin
      mem_resp_valid <= 1'b0;
    end
  end

  // Route rides along so the demux can steer the answer back
  always_ff @(posedge ap_clk) begin
    if (accept) begin
      mem_resp.route   <= mem_req.route;
      mem_resp.cmd     <= mem_req.cmd;
      mem_resp.address <= mem_req.address;
      // Write acknowledges with the data it stored
      if (is_write) begin
        mem_resp.data <= mem_req.data;
      end else begin
        mem_resp.data <= words[mem_req.address];
      end
    end
  end

endmodule

/* verilog/sync_fifo.sv */
// First-word-fall-through FIFO, no reset latency. push_ready and pop_valid
// come from the count register only
`timescale 1ns/10ps

module sync_fifo #(
  parameter type payload_t = logic,
  parameter int  depth     = 4
) (
  input  logic                       ap_clk,
  input  logic                       areset_control,
  input  logic                       push_valid,
  input  payload_t                   push_data,
  output logic                       push_ready,
  output logic                       pop_valid,
  output payload_t                   pop_data,
  input  logic                       pop_ready,
  output logic [$clog2(depth+1)-1:0] free_count
);

  typedef logic [$clog2(depth)-1:0]   ptr_t;
  typedef logic [$clog2(depth+1)-1:0] count_t;

  payload_t storage [depth];

  ptr_t   wr_ptr;
  ptr_t   rd_ptr;
  count_t count;

  logic push;
  logic pop;

  assign push_ready = (count != count_t'(depth));
  assign pop_valid  = (count != '0);
  assign push       = push_valid & push_ready;
  assign pop        = pop_valid & pop_ready;

  // Head of the queue is always visible
  assign pop_data   = storage[rd_ptr];
  assign free_count = count_t'(depth) - count;

  always_ff @(posedge ap_clk) begin
    if (push) begin
      storage[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        if (wr_ptr == ptr_t'(depth - 1)) begin
          wr_ptr <= '0;
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
      if (pop) begin
        if (rd_ptr == ptr_t'(depth - 1)) begin
          rd_ptr <= '0;
        end else begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
      // Simultaneous push and pop leaves the count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule
